// ==== Bender.yml ====
package:
  name: mem_exerciser

sources:
  - common/exer_pkg.sv
  - traffic/pattern_gen.sv
  - traffic/traffic_gen.sv
  - mem/line_memory.sv
  - logic/read_checker.sv
  - logic/mem_exerciser_top.sv
  - target: simulation
    files:
      - verif/tb_mem_exerciser.sv

// ==== common/exer_pkg.sv ====
package exer_pkg;

	////////////////////////////////////////////////////////////
	// Line and address geometry
	////////////////////////////////////////////////////////////
	localparam int LINE_W     = 256;
	localparam int ADDR_W     = 28;
	localparam int WORD_W     = 32;
	localparam int LINE_WORDS = LINE_W / WORD_W;
	localparam int MEM_LINES  = 64;
	localparam int ADDR_STEP  = 8;
	localparam int IDX_W      = $clog2(MEM_LINES);
	localparam int STEP_SHIFT = $clog2(ADDR_STEP);

	// Run setting widths
	localparam int CNT_W = 8;
	localparam int GAP_W = 6;

	////////////////////////////////////////////////////////////
	// Memory timing
	////////////////////////////////////////////////////////////
	localparam int WR_LATENCY = 3;
	localparam int RD_LATENCY = 5;
	localparam int LAT_W      = 3;

	// Counter load values, completion when the counter hits zero
	localparam logic [LAT_W-1:0] WR_LAT_LOAD = LAT_W'(WR_LATENCY - 1);
	localparam logic [LAT_W-1:0] RD_LAT_LOAD = LAT_W'(RD_LATENCY - 1);

	// Pattern mixing constants
	localparam logic [WORD_W-1:0] PAT_LINE_MUL = 32'h9E37_79B9;
	localparam logic [WORD_W-1:0] PAT_WORD_MUL = 32'h0101_0101;

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} mem_op_e;

	typedef enum logic [1:0] {
		MODE_WRITE_VERIFY = 2'd0,
		MODE_WRITE_ONLY   = 2'd1,
		MODE_VERIFY_ONLY  = 2'd2
	} run_mode_e;

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_ISSUE = 2'd1,
		ST_GAP   = 2'd2,
		ST_DONE  = 2'd3
	} traffic_state_e;

endpackage

// ==== logic/mem_exerciser_top.sv ====
module mem_exerciser_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        start,
	input  exer_pkg::run_mode_e         mode,
	input  logic [exer_pkg::WORD_W-1:0] seed,
	input  logic [exer_pkg::ADDR_W-1:0] base_addr,
	input  logic [exer_pkg::CNT_W-1:0]  num_lines,
	input  logic [exer_pkg::GAP_W-1:0]  gap_cycles,
	output logic                        busy,
	output logic                        done,
	output logic                        error,
	output logic [exer_pkg::CNT_W-1:0]  err_count,
	output logic [exer_pkg::ADDR_W-1:0] first_err_addr
);

	// Memory command path
	logic                        cmd_valid;
	exer_pkg::mem_op_e           cmd_op;
	logic [exer_pkg::ADDR_W-1:0] cmd_addr;
	logic [exer_pkg::LINE_W-1:0] cmd_wdata;
	logic                        mem_ready;
	logic [exer_pkg::LINE_W-1:0] mem_rdata;

	// Pattern lookup
	logic [exer_pkg::CNT_W-1:0]  pat_index;
	logic [exer_pkg::WORD_W-1:0] pat_seed;
	logic [exer_pkg::LINE_W-1:0] pat_line;

	// Checker feed
	logic                        chk_valid;
	logic [exer_pkg::ADDR_W-1:0] chk_addr;
	logic [exer_pkg::LINE_W-1:0] chk_expect;
	logic [exer_pkg::LINE_W-1:0] chk_rdata;

	traffic_gen u_traffic_gen (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.mode       (mode),
		.seed       (seed),
		.base_addr  (base_addr),
		.num_lines  (num_lines),
		.gap_cycles (gap_cycles),
		.mem_ready  (mem_ready),
		.mem_rdata  (mem_rdata),
		.pat_line   (pat_line),
		.cmd_valid  (cmd_valid),
		.cmd_op     (cmd_op),
		.cmd_addr   (cmd_addr),
		.cmd_wdata  (cmd_wdata),
		.pat_index  (pat_index),
		.pat_seed   (pat_seed),
		.chk_valid  (chk_valid),
		.chk_addr   (chk_addr),
		.chk_expect (chk_expect),
		.chk_rdata  (chk_rdata),
		.busy       (busy),
		.done       (done)
	);

	pattern_gen u_pattern_gen (
		.pat_seed  (pat_seed),
		.pat_index (pat_index),
		.pat_line  (pat_line)
	);

	line_memory u_line_memory (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_addr  (cmd_addr),
		.cmd_wdata (cmd_wdata),
		.mem_ready (mem_ready),
		.mem_rdata (mem_rdata)
	);

	// Checker clears only on a start the generator accepts
	read_checker u_read_checker (
		.clk            (clk),
		.rst            (rst),
		.start          (start && !busy),
		.chk_valid      (chk_valid),
		.chk_addr       (chk_addr),
		.chk_expect     (chk_expect),
		.chk_rdata      (chk_rdata),
		.error          (error),
		.err_count      (err_count),
		.first_err_addr (first_err_addr)
	);

endmodule

// ==== logic/read_checker.sv ====
module read_checker (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        start,
	input  logic                        chk_valid,
	input  logic [exer_pkg::ADDR_W-1:0] chk_addr,
	input  logic [exer_pkg::LINE_W-1:0] chk_expect,
	input  logic [exer_pkg::LINE_W-1:0] chk_rdata,
	output logic                        error,
	output logic [exer_pkg::CNT_W-1:0]  err_count,
	output logic [exer_pkg::ADDR_W-1:0] first_err_addr
);

	logic mismatch;
	logic count_full;

	assign mismatch   = chk_valid && (chk_rdata != chk_expect);
	assign count_full = (err_count == '1);

	////////////////////////////////////////////////////////////
	// Result registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			error          <= 1'b0;
			err_count      <= '0;
			first_err_addr <= '0;
		end
		else if (start)
		begin
			// New run starts with a clean slate
			error          <= 1'b0;
			err_count      <= '0;
			first_err_addr <= '0;
		end
		else if (mismatch)
		begin
			error <= 1'b1;
			// Saturating count of failing lines
			if (!count_full)
				err_count <= err_count + 1'b1;
			// Only the first failure of the run is kept
			if (!error)
				first_err_addr <= chk_addr;
		end
	end

endmodule

// ==== mem/line_memory.sv ====
module line_memory (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        cmd_valid,
	input  exer_pkg::mem_op_e           cmd_op,
	input  logic [exer_pkg::ADDR_W-1:0] cmd_addr,
	input  logic [exer_pkg::LINE_W-1:0] cmd_wdata,
	output logic                        mem_ready,
	output logic [exer_pkg::LINE_W-1:0] mem_rdata
);

	// Line storage, keeps its contents across reset
	logic [exer_pkg::LINE_W-1:0] mem_q [exer_pkg::MEM_LINES];

	logic                        busy_q;
	logic [exer_pkg::LAT_W-1:0]  lat_q;

	// Command captured at accept
	exer_pkg::mem_op_e           op_q;
	logic [exer_pkg::IDX_W-1:0]  idx_q;
	logic [exer_pkg::LINE_W-1:0] wdata_q;

	logic accept;

	// One command in flight, valid is ignored until it completes
	assign accept    = cmd_valid && !busy_q;
	assign mem_ready = busy_q && (lat_q == '0);

	////////////////////////////////////////////////////////////
	// Latency counter
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy_q <= 1'b0;
			lat_q  <= '0;
		end
		else if (accept)
		begin
			busy_q <= 1'b1;
			if (cmd_op == exer_pkg::OP_WRITE)
				lat_q <= exer_pkg::WR_LAT_LOAD;
			else
				lat_q <= exer_pkg::RD_LAT_LOAD;
		end
		else if (mem_ready)
			busy_q <= 1'b0;
		else if (busy_q)
			lat_q <= lat_q - 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			op_q    <= cmd_op;
			// Index is addr / ADDR_STEP, wrapped to the store size
			idx_q   <= cmd_addr[exer_pkg::STEP_SHIFT +: exer_pkg::IDX_W];
			wdata_q <= cmd_wdata;
		end
	end

	////////////////////////////////////////////////////////////
	// Storage access
	////////////////////////////////////////////////////////////

	// Write lands in the completion cycle
	always_ff @(posedge clk)
	begin
		if (mem_ready && op_q == exer_pkg::OP_WRITE)
			mem_q[idx_q] <= wdata_q;
	end

	// Read data meaningful only with mem_ready of a read
	assign mem_rdata = mem_q[idx_q];

endmodule

// ==== mem_exerciser_top.f ====
common/exer_pkg.sv
traffic/pattern_gen.sv
traffic/traffic_gen.sv
mem/line_memory.sv
logic/read_checker.sv
logic/mem_exerciser_top.sv
verif/tb_mem_exerciser.sv

// ==== traffic/pattern_gen.sv ====
module pattern_gen (
	input  logic [exer_pkg::WORD_W-1:0] pat_seed,
	input  logic [exer_pkg::CNT_W-1:0]  pat_index,
	output logic [exer_pkg::LINE_W-1:0] pat_line
);

	logic [exer_pkg::WORD_W-1:0] line_base;
	logic [exer_pkg::WORD_W-1:0] index_ext;
	logic [4:0]                  rot;

	assign index_ext = {{(exer_pkg::WORD_W - exer_pkg::CNT_W){1'b0}}, pat_index};

	// Per-line term, shared by all eight words
	assign line_base = pat_seed + index_ext * exer_pkg::PAT_LINE_MUL;

	// Rotation by line index mod 32
	assign rot = pat_index[4:0];

	////////////////////////////////////////////////////////////
	// Word mixer
	////////////////////////////////////////////////////////////
	always_comb
	begin
		logic [exer_pkg::WORD_W-1:0] sum;
		logic [exer_pkg::WORD_W-1:0] word_k;

		pat_line = '0;
		for (int k = 0; k < exer_pkg::LINE_WORDS; k++)
		begin
			word_k = exer_pkg::WORD_W'(k);
			sum    = line_base + word_k * exer_pkg::PAT_WORD_MUL;
			// Left rotation, the wrapped part is empty for a zero rotation
			pat_line[k*exer_pkg::WORD_W +: exer_pkg::WORD_W] =
				(sum << rot) | (sum >> (6'd32 - {1'b0, rot}));
		end
	end

endmodule

// ==== traffic/traffic_gen.sv ====
module traffic_gen (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           start,
	input  exer_pkg::run_mode_e            mode,
	input  logic [exer_pkg::WORD_W-1:0]    seed,
	input  logic [exer_pkg::ADDR_W-1:0]    base_addr,
	input  logic [exer_pkg::CNT_W-1:0]     num_lines,
	input  logic [exer_pkg::GAP_W-1:0]     gap_cycles,
	input  logic                           mem_ready,
	input  logic [exer_pkg::LINE_W-1:0]    mem_rdata,
	input  logic [exer_pkg::LINE_W-1:0]    pat_line,
	output logic                           cmd_valid,
	output exer_pkg::mem_op_e              cmd_op,
	output logic [exer_pkg::ADDR_W-1:0]    cmd_addr,
	output logic [exer_pkg::LINE_W-1:0]    cmd_wdata,
	output logic [exer_pkg::CNT_W-1:0]     pat_index,
	output logic [exer_pkg::WORD_W-1:0]    pat_seed,
	output logic                           chk_valid,
	output logic [exer_pkg::ADDR_W-1:0]    chk_addr,
	output logic [exer_pkg::LINE_W-1:0]    chk_expect,
	output logic [exer_pkg::LINE_W-1:0]    chk_rdata,
	output logic                           busy,
	output logic                           done
);

	exer_pkg::traffic_state_e state_q;
	exer_pkg::mem_op_e        op_q;
	logic [exer_pkg::CNT_W-1:0] idx_q;
	logic [exer_pkg::GAP_W-1:0] gap_cnt_q;

	// Run settings captured at start
	exer_pkg::run_mode_e         mode_q;
	logic [exer_pkg::WORD_W-1:0] seed_q;
	logic [exer_pkg::ADDR_W-1:0] base_q;
	logic [exer_pkg::CNT_W-1:0]  lines_q;
	logic [exer_pkg::GAP_W-1:0]  gap_q;

	logic start_ok;
	logic cmd_done;
	logic last_line;
	logic run_end;
	logic [exer_pkg::ADDR_W-1:0] line_off;

	// Start is taken in IDLE and in the one-cycle DONE state
	assign start_ok  = start && (state_q == exer_pkg::ST_IDLE || state_q == exer_pkg::ST_DONE);
	assign cmd_done  = cmd_valid && mem_ready;
	assign last_line = (idx_q + 1'b1 == lines_q);
	// Write pass of a write-verify run rolls over into the read pass
	assign run_end   = last_line &&
		!(op_q == exer_pkg::OP_WRITE && mode_q == exer_pkg::MODE_WRITE_VERIFY);

	////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q   <= exer_pkg::ST_IDLE;
			op_q      <= exer_pkg::OP_WRITE;
			idx_q     <= '0;
			gap_cnt_q <= '0;
		end
		else
		begin
			case (state_q)
				exer_pkg::ST_IDLE, exer_pkg::ST_DONE:
				begin
					if (start_ok)
					begin
						idx_q   <= '0;
						op_q    <= (mode == exer_pkg::MODE_VERIFY_ONLY) ?
							exer_pkg::OP_READ : exer_pkg::OP_WRITE;
						state_q <= exer_pkg::ST_ISSUE;
					end
					else
						state_q <= exer_pkg::ST_IDLE;
				end
				exer_pkg::ST_ISSUE:
				begin
					if (cmd_done)
					begin
						if (last_line)
						begin
							idx_q <= '0;
							op_q  <= exer_pkg::OP_READ;
						end
						else
							idx_q <= idx_q + 1'b1;
						if (run_end)
							state_q <= exer_pkg::ST_DONE;
						else if (gap_q != '0)
						begin
							gap_cnt_q <= gap_q;
							state_q   <= exer_pkg::ST_GAP;
						end
					end
				end
				default:
				begin
					// Idle spacing, counts down to the next command
					gap_cnt_q <= gap_cnt_q - 1'b1;
					if (gap_cnt_q == 1)
						state_q <= exer_pkg::ST_ISSUE;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (start_ok)
		begin
			mode_q  <= mode;
			seed_q  <= seed;
			base_q  <= base_addr;
			lines_q <= num_lines;
			gap_q   <= gap_cycles;
		end
	end

	////////////////////////////////////////////////////////////
	// Command and checker outputs
	////////////////////////////////////////////////////////////
	assign line_off = {{(exer_pkg::ADDR_W - exer_pkg::CNT_W - exer_pkg::STEP_SHIFT){1'b0}},
		idx_q, {exer_pkg::STEP_SHIFT{1'b0}}};

	assign cmd_valid = (state_q == exer_pkg::ST_ISSUE);
	assign cmd_op    = op_q;
	assign cmd_addr  = base_q + line_off;
	assign cmd_wdata = pat_line;
	assign pat_index = idx_q;
	assign pat_seed  = seed_q;

	// Checker sees every read in its completion cycle
	assign chk_valid  = cmd_done && (op_q == exer_pkg::OP_READ);
	assign chk_addr   = cmd_addr;
	assign chk_expect = pat_line;
	assign chk_rdata  = mem_rdata;

	assign busy = (state_q == exer_pkg::ST_ISSUE) || (state_q == exer_pkg::ST_GAP);
	assign done = (state_q == exer_pkg::ST_DONE);

endmodule

// ==== verif/exerciser_vectors.txt ====
# mode (0 write-verify, 1 write-only, 2 verify-only), seed (hex), base_addr (hex), num_lines,
# gap_cycles, expected err_count, expected first_err_addr (hex)
0 12345678 0000000 16 0 0 0000000
0 cafef00d fffff00 64 3 0 0000000
1 a5a50001 0000400 32 1 0 0000000
2 a5a50001 0000400 32 2 0 0000000
2 5a5a0002 0000400 32 0 32 0000400
1 0badbeef 0001000 8 0 0 0000000
1 600df00d 0001020 4 1 0 0000000
2 0badbeef 0001000 8 0 4 0001020
2 a5a50001 0000400 32 0 8 0000400
2 cafef00d fffff00 48 1 16 0000000
0 00000001 0000208 1 0 0 0000000
0 ffffffff 0abcde0 40 63 0 0000000
2 ffffffff 0abcde0 40 5 0 0000000
1 13579bdf 0000000 64 0 0 0000000
2 13579bdf 0000000 64 2 0 0000000

// ==== verif/tb_mem_exerciser.sv ====
module tb_mem_exerciser;

	logic                        clk;
	logic                        rst;
	logic                        start;
	exer_pkg::run_mode_e         mode;
	logic [exer_pkg::WORD_W-1:0] seed;
	logic [exer_pkg::ADDR_W-1:0] base_addr;
	logic [exer_pkg::CNT_W-1:0]  num_lines;
	logic [exer_pkg::GAP_W-1:0]  gap_cycles;
	logic                        busy;
	logic                        done;
	logic                        error;
	logic [exer_pkg::CNT_W-1:0]  err_count;
	logic [exer_pkg::ADDR_W-1:0] first_err_addr;

	// One entry per run vector
	int          v_mode[$];
	logic [31:0] v_seed[$];
	logic [27:0] v_base[$];
	int          v_num[$];
	int          v_gap[$];
	int          v_count[$];
	logic [27:0] v_first[$];

	// Line store as the vectors should leave it
	logic [255:0] shadow [exer_pkg::MEM_LINES];

	int cycle_count;
	int cycle_limit;
	int done_count;

	mem_exerciser_top dut (.*);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (!rst && done)
			done_count <= done_count + 1;
		if (cycle_count >= cycle_limit)
			abort_run($sformatf("Timeout: runs not finished after %0d cycles", cycle_count));
	end

	////////////////////////////////////////////////////////////
	// Checks and failure exits
	////////////////////////////////////////////////////////////
	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
			$display(">>> FAIL");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "Run aborted");
	endtask

	////////////////////////////////////////////////////////////
	// Reference model of patterns and line placement
	////////////////////////////////////////////////////////////
	function automatic logic [255:0] line_pattern(input logic [31:0] s, input int n);
		logic [31:0]  w;
		logic [255:0] line;
		int           r;
		r = n % 32;
		for (int k = 0; k < 8; k++)
		begin
			w = s + 32'(n) * 32'h9E37_79B9 + 32'(k) * 32'h0101_0101;
			if (r != 0)
				w = (w << r) | (w >> (32 - r));
			line[k*32 +: 32] = w;
		end
		return line;
	endfunction

	function automatic logic [27:0] line_addr(input logic [27:0] base, input int n);
		return base + 28'(n * exer_pkg::ADDR_STEP);
	endfunction

	function automatic int line_slot(input logic [27:0] addr);
		return (addr / exer_pkg::ADDR_STEP) % exer_pkg::MEM_LINES;
	endfunction

	// Replays one vector on the shadow store and confirms the file
	task automatic model_run(input int v);
		int          cnt;
		logic [27:0] first;
		logic [27:0] addr;
		cnt   = 0;
		first = '0;
		if (v_mode[v] != exer_pkg::MODE_VERIFY_ONLY)
			for (int n = 0; n < v_num[v]; n++)
				shadow[line_slot(line_addr(v_base[v], n))] = line_pattern(v_seed[v], n);
		if (v_mode[v] != exer_pkg::MODE_WRITE_ONLY)
			for (int n = 0; n < v_num[v]; n++)
			begin
				addr = line_addr(v_base[v], n);
				if (shadow[line_slot(addr)] !== line_pattern(v_seed[v], n))
				begin
					if (cnt == 0)
						first = addr;
					cnt++;
				end
			end
		check_value($sformatf("vector %0d err_count in file", v), v_count[v], cnt);
		check_value($sformatf("vector %0d first_err_addr in file", v), v_first[v], first);
	endtask

	task automatic load_vectors();
		int          fd;
		int          r;
		string       line;
		int          md;
		int          nl;
		int          gp;
		int          ec;
		logic [31:0] sd;
		logic [31:0] ba;
		logic [31:0] fa;
		fd = $fopen("verif/exerciser_vectors.txt", "r");
		if (fd == 0)
			abort_run("Cannot open verif/exerciser_vectors.txt");
		while (!$feof(fd))
		begin
			line = "";
			r = $fgets(line, fd);
			if (line.len() > 0 && line.substr(0, 0) != "#")
			begin
				r = $sscanf(line, "%d %h %h %d %d %d %h", md, sd, ba, nl, gp, ec, fa);
				if (r == 7)
				begin
					v_mode.push_back(md);
					v_seed.push_back(sd);
					v_base.push_back(ba[27:0]);
					v_num.push_back(nl);
					v_gap.push_back(gp);
					v_count.push_back(ec);
					v_first.push_back(fa[27:0]);
					cycle_limit += 2 * nl * (exer_pkg::RD_LATENCY + gp + 2);
				end
				else if (r > 0)
					abort_run($sformatf("Malformed line in vector file: %s", line));
			end
		end
		$fclose(fd);
		if (v_mode.size() == 0)
			abort_run("Vector file holds no runs");
	endtask

	////////////////////////////////////////////////////////////
	// Run driver
	////////////////////////////////////////////////////////////
	task automatic run_vector(input int v);
		mode       = exer_pkg::run_mode_e'(v_mode[v]);
		seed       = v_seed[v];
		base_addr  = v_base[v];
		num_lines  = exer_pkg::CNT_W'(v_num[v]);
		gap_cycles = exer_pkg::GAP_W'(v_gap[v]);
		start      = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_value($sformatf("run %0d busy after start", v), busy, 1);
		@(negedge clk);
		// Second start mid-run with other settings
		if (busy)
		begin
			mode  = exer_pkg::MODE_VERIFY_ONLY;
			seed  = ~v_seed[v];
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
			mode  = exer_pkg::run_mode_e'(v_mode[v]);
			seed  = v_seed[v];
		end
		while (!done)
			@(negedge clk);
		check_value($sformatf("run %0d busy in done cycle", v), busy, 0);
		check_value($sformatf("run %0d error", v), error, v_count[v] != 0);
		check_value($sformatf("run %0d err_count", v), err_count, v_count[v]);
		check_value($sformatf("run %0d first_err_addr", v), first_err_addr, v_first[v]);
		@(negedge clk);
		check_value($sformatf("run %0d done pulses", v), done_count, v + 1);
	endtask

	initial
	begin
		clk         = 1'b0;
		rst         = 1'b1;
		start       = 1'b0;
		mode        = exer_pkg::MODE_WRITE_VERIFY;
		seed        = '0;
		base_addr   = '0;
		num_lines   = 8'd1;
		gap_cycles  = '0;
		cycle_count = 0;
		cycle_limit = 100;
		done_count  = 0;
		load_vectors();
		for (int v = 0; v < v_mode.size(); v++)
			model_run(v);
		repeat (8) @(negedge clk);
		check_value("busy in reset", busy, 0);
		check_value("done in reset", done, 0);
		check_value("error in reset", error, 0);
		check_value("err_count in reset", err_count, 0);
		rst = 1'b0;
		repeat (2) @(negedge clk);
		for (int v = 0; v < v_mode.size(); v++)
		begin
			run_vector(v);
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
		check_value("total done pulses", done_count, v_mode.size());
		$display(">>> PASS");
		$finish;
	end

endmodule
